// ==== filelist.f ====
src/csr_defs_pkg.sv
src/trap_cause_pkg.sv
src/trap_handler.sv
src/machine_csr_file.sv
src/trap_unit_top.sv
tests/trap_unit_sva.sv
tests/trap_unit_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module trap_unit_tb -f filelist.f -o Vtrap_unit_tb

out=$(./obj_dir/Vtrap_unit_tb 2>&1) || { printf '%s\n' "$out"; exit 1; }
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qF '*** PASSED ***'; then
  exit 0
else
  exit 1
fi

// ==== src/csr_defs_pkg.sv ====
// register width, machine CSR addresses, mstatus and mtvec fields, mcause union type
`default_nettype none

package csr_defs_pkg;

  // register width of the core
  localparam int XLEN = 64;

  // width of a CSR address
  localparam int CSR_ADDR_W = 12;

  // machine CSR addresses handled by the trap unit
  localparam logic [CSR_ADDR_W-1:0] CSR_MSTATUS = 12'h300;
  localparam logic [CSR_ADDR_W-1:0] CSR_MIE     = 12'h304;
  localparam logic [CSR_ADDR_W-1:0] CSR_MTVEC   = 12'h305;
  localparam logic [CSR_ADDR_W-1:0] CSR_MEPC    = 12'h341;
  localparam logic [CSR_ADDR_W-1:0] CSR_MCAUSE  = 12'h342;
  localparam logic [CSR_ADDR_W-1:0] CSR_MTVAL   = 12'h343;
  localparam logic [CSR_ADDR_W-1:0] CSR_MIP     = 12'h344;

  // mstatus interrupt enable bits
  localparam int MSTATUS_MIE  = 3;
  localparam int MSTATUS_MPIE = 7;

  // mtvec mode field, low two bits
  localparam logic [1:0] MTVEC_MODE_DIRECT   = 2'd0;
  localparam logic [1:0] MTVEC_MODE_VECTORED = 2'd1;

  // mcause has one flag bit on top, the rest is the code.
  // the code field is read as an exception code or an
  // interrupt code depending on that flag
  typedef union packed {
    struct packed {
      logic            intr;
      logic [XLEN-2:0] excp_code;
    } excp_view;
    struct packed {
      logic            intr;
      logic [XLEN-2:0] itrp_code;
    } itrp_view;
  } mcause_u;

endpackage

`default_nettype wire

// ==== src/machine_csr_file.sv ====
// machine_csr_file: machine CSR registers, software port, irq sampling and trap updates
`default_nettype none

module machine_csr_file
  import csr_defs_pkg::*;
  import trap_cause_pkg::*;
(
  input  logic                  clk,
  input  logic                  arst_n,

  // interrupt lines
  input  logic                  soft_irq,
  input  logic                  timer_irq,
  input  logic                  exter_irq,

  // software access
  input  logic [CSR_ADDR_W-1:0] csr_rd_addr,
  output logic [XLEN-1:0]       csr_rd_data,
  input  logic                  csr_wr_en,
  input  logic [CSR_ADDR_W-1:0] csr_wr_addr,
  input  logic [XLEN-1:0]       csr_wr_data,

  // updates from the trap handler
  input  logic                  trap_enter,
  input  logic                  excp_exit,
  input  mcause_u               mcause_wr_data,
  input  logic [XLEN-1:0]       mepc_wr_data,
  input  logic [XLEN-1:0]       mtval_wr_data,
  input  logic [XLEN-1:0]       mstatus_wr_data,

  // current values to the trap handler
  output logic [XLEN-1:0]       mstatus,
  output logic [XLEN-1:0]       mtvec,
  output logic [XLEN-1:0]       mepc,
  output logic [XLEN-1:0]       mie,
  output logic [XLEN-1:0]       mip
);

  mcause_u         mcause;
  logic [XLEN-1:0] mtval;
  logic [XLEN-1:0] mip_next;
  logic            wr_mstatus;
  logic            wr_mie;
  logic            wr_mtvec;
  logic            wr_mepc;
  logic            wr_mcause;
  logic            wr_mtval;

  // software write decode
  assign wr_mstatus = csr_wr_en && (csr_wr_addr == CSR_MSTATUS);
  assign wr_mie     = csr_wr_en && (csr_wr_addr == CSR_MIE);
  assign wr_mtvec   = csr_wr_en && (csr_wr_addr == CSR_MTVEC);
  assign wr_mepc    = csr_wr_en && (csr_wr_addr == CSR_MEPC);
  assign wr_mcause  = csr_wr_en && (csr_wr_addr == CSR_MCAUSE);
  assign wr_mtval   = csr_wr_en && (csr_wr_addr == CSR_MTVAL);

  // mip only carries the three irq lines
  always_comb begin
    mip_next             = '0;
    mip_next[ITRP_SOFT]  = soft_irq;
    mip_next[ITRP_TIMER] = timer_irq;
    mip_next[ITRP_EXTER] = exter_irq;
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      mstatus <= '0;
      mtvec   <= '0;
      mepc    <= '0;
      mcause  <= '0;
      mtval   <= '0;
      mie     <= '0;
      mip     <= '0;
    end else begin
      mip <= mip_next;

      // trap entry and return go ahead of software
      if (trap_enter || excp_exit) begin
        mstatus <= mstatus_wr_data;
      end else if (wr_mstatus) begin
        mstatus <= csr_wr_data;
      end

      if (trap_enter) begin
        mepc   <= mepc_wr_data;
        mcause <= mcause_wr_data;
        mtval  <= mtval_wr_data;
      end else begin
        if (wr_mepc) begin
          mepc <= csr_wr_data;
        end
        if (wr_mcause) begin
          mcause <= csr_wr_data;
        end
        if (wr_mtval) begin
          mtval <= csr_wr_data;
        end
      end

      // reserved modes fall back to direct
      if (wr_mtvec) begin
        if (csr_wr_data[1:0] == MTVEC_MODE_VECTORED) begin
          mtvec <= csr_wr_data;
        end else begin
          mtvec <= {csr_wr_data[XLEN-1:2], MTVEC_MODE_DIRECT};
        end
      end

      // only implemented enable bits
      if (wr_mie) begin
        mie[ITRP_SOFT]  <= csr_wr_data[ITRP_SOFT];
        mie[ITRP_TIMER] <= csr_wr_data[ITRP_TIMER];
        mie[ITRP_EXTER] <= csr_wr_data[ITRP_EXTER];
      end
    end
  end

  // read mux, unknown addresses read zero
  always_comb begin
    case (csr_rd_addr)
      CSR_MSTATUS: csr_rd_data = mstatus;
      CSR_MIE:     csr_rd_data = mie;
      CSR_MTVEC:   csr_rd_data = mtvec;
      CSR_MEPC:    csr_rd_data = mepc;
      CSR_MCAUSE:  csr_rd_data = mcause;
      CSR_MTVAL:   csr_rd_data = mtval;
      CSR_MIP:     csr_rd_data = mip;
      default:     csr_rd_data = '0;
    endcase
  end

endmodule

`default_nettype wire

// ==== src/trap_cause_pkg.sv ====
// exception strobe positions, exception and interrupt codes, interrupt bit positions
`default_nettype none

package trap_cause_pkg;

  // width of the exception strobe vector from the pipeline
  localparam int EXCP_W = 12;

  // strobe bit positions in excp_info
  localparam int EXCP_INST_MISAL = 0;
  localparam int EXCP_INST_ACC   = 1;
  localparam int EXCP_ILG_INST   = 2;
  localparam int EXCP_BRK_PT     = 3;
  localparam int EXCP_LOAD_MISAL = 4;
  localparam int EXCP_LOAD_ACC   = 5;
  localparam int EXCP_STOR_MISAL = 6;
  localparam int EXCP_STOR_ACC   = 7;
  localparam int EXCP_ECALL_M    = 8;
  localparam int EXCP_INST_PAGE  = 9;
  localparam int EXCP_LOAD_PAGE  = 10;
  localparam int EXCP_STOR_PAGE  = 11;

  // width of a cause code before extension to the mcause field
  localparam int CAUSE_W = 6;

  // exception codes as written to mcause
  localparam logic [CAUSE_W-1:0] CODE_INST_MISAL = 6'd0;
  localparam logic [CAUSE_W-1:0] CODE_INST_ACC   = 6'd1;
  localparam logic [CAUSE_W-1:0] CODE_ILG_INST   = 6'd2;
  localparam logic [CAUSE_W-1:0] CODE_BRK_PT     = 6'd3;
  localparam logic [CAUSE_W-1:0] CODE_LOAD_MISAL = 6'd4;
  localparam logic [CAUSE_W-1:0] CODE_LOAD_ACC   = 6'd5;
  localparam logic [CAUSE_W-1:0] CODE_STOR_MISAL = 6'd6;
  localparam logic [CAUSE_W-1:0] CODE_STOR_ACC   = 6'd7;
  localparam logic [CAUSE_W-1:0] CODE_ECALL_M    = 6'd11;
  localparam logic [CAUSE_W-1:0] CODE_INST_PAGE  = 6'd12;
  localparam logic [CAUSE_W-1:0] CODE_LOAD_PAGE  = 6'd13;
  localparam logic [CAUSE_W-1:0] CODE_STOR_PAGE  = 6'd15;

  // code lookup indexed by strobe position
  localparam logic [CAUSE_W-1:0] EXCP_CODE_TAB [EXCP_W] = '{
    CODE_INST_MISAL, CODE_INST_ACC, CODE_ILG_INST, CODE_BRK_PT,
    CODE_LOAD_MISAL, CODE_LOAD_ACC, CODE_STOR_MISAL, CODE_STOR_ACC,
    CODE_ECALL_M, CODE_INST_PAGE, CODE_LOAD_PAGE, CODE_STOR_PAGE
  };

  // interrupt codes, same values as their bits in mie and mip
  localparam int ITRP_SOFT  = 3;
  localparam int ITRP_TIMER = 7;
  localparam int ITRP_EXTER = 11;

endpackage

`default_nettype wire

// ==== src/trap_handler.sv ====
// trap_handler: combinational trap entry and return, CSR update values and redirect target
`default_nettype none

module trap_handler
  import csr_defs_pkg::*;
  import trap_cause_pkg::*;
(
  // from the pipeline
  input  logic [EXCP_W-1:0] excp_info,
  input  logic [XLEN-1:0]   now_pc,
  input  logic [31:0]       now_inst,
  input  logic [XLEN-1:0]   mem_addr,
  input  logic              excp_exit,

  // current CSR values
  input  logic [XLEN-1:0]   mstatus,
  input  logic [XLEN-1:0]   mtvec,
  input  logic [XLEN-1:0]   mepc,
  input  logic [XLEN-1:0]   mie,
  input  logic [XLEN-1:0]   mip,

  // CSR update strobe and values
  output logic              trap_enter,
  output logic              itrp_valid,
  output mcause_u           mcause_wr_data,
  output logic [XLEN-1:0]   mepc_wr_data,
  output logic [XLEN-1:0]   mtval_wr_data,
  output logic [XLEN-1:0]   mstatus_wr_data,

  // redirect to fetch
  output logic              trap_jmp_ena,
  output logic [XLEN-1:0]   trap_jmp_pc,

  // difftest cause numbers
  output logic [31:0]       itrp_no,
  output logic [31:0]       excp_no
);

  logic               pend_soft;
  logic               pend_timer;
  logic               pend_exter;
  logic               itrp_allowin;
  logic               excp_any;
  logic               excp_taken;
  logic [CAUSE_W-1:0] itrp_code;
  logic [CAUSE_W-1:0] excp_code;
  logic               inst_fault;
  logic               mem_fault;
  logic [XLEN-1:0]    mstatus_enter;
  logic [XLEN-1:0]    mstatus_exit;
  logic               mtvec_vectored;
  logic [XLEN-1:0]    mtvec_base;
  logic [XLEN-1:0]    enter_pc;

  // pending and enabled interrupts
  assign pend_soft  = mie[ITRP_SOFT] & mip[ITRP_SOFT];
  assign pend_timer = mie[ITRP_TIMER] & mip[ITRP_TIMER];
  assign pend_exter = mie[ITRP_EXTER] & mip[ITRP_EXTER];

  assign itrp_allowin = mstatus[MSTATUS_MIE] & (pend_soft | pend_timer | pend_exter);
  assign excp_any     = |excp_info;

  // an interrupt wins over a concurrent exception
  assign excp_taken = excp_any & ~itrp_allowin;
  assign itrp_valid = itrp_allowin;
  assign trap_enter = excp_any | itrp_allowin;

  // external, then software, then timer
  always_comb begin
    if (pend_exter) begin
      itrp_code = CAUSE_W'(ITRP_EXTER);
    end else if (pend_soft) begin
      itrp_code = CAUSE_W'(ITRP_SOFT);
    end else if (pend_timer) begin
      itrp_code = CAUSE_W'(ITRP_TIMER);
    end else begin
      itrp_code = '0;
    end
  end

  // strobe is one-hot, so or-ing the table entries gives the code
  always_comb begin
    excp_code = '0;
    for (int i = 0; i < EXCP_W; i++) begin
      if (excp_info[i]) begin
        excp_code |= EXCP_CODE_TAB[i];
      end
    end
  end

  assign inst_fault = excp_info[EXCP_INST_MISAL] | excp_info[EXCP_INST_ACC]
                    | excp_info[EXCP_INST_PAGE];
  assign mem_fault  = excp_info[EXCP_LOAD_MISAL] | excp_info[EXCP_LOAD_ACC]
                    | excp_info[EXCP_STOR_MISAL] | excp_info[EXCP_STOR_ACC]
                    | excp_info[EXCP_LOAD_PAGE]  | excp_info[EXCP_STOR_PAGE];

  // mcause through the view of the trap kind
  always_comb begin
    mcause_wr_data = '0;
    if (itrp_allowin) begin
      mcause_wr_data.itrp_view.intr      = 1'b1;
      mcause_wr_data.itrp_view.itrp_code = (XLEN-1)'(itrp_code);
    end else begin
      mcause_wr_data.excp_view.intr      = 1'b0;
      mcause_wr_data.excp_view.excp_code = (XLEN-1)'(excp_code);
    end
  end

  assign mepc_wr_data = now_pc;

  // faulting address or instruction, zero for the rest
  always_comb begin
    mtval_wr_data = '0;
    if (excp_taken && inst_fault) begin
      mtval_wr_data = now_pc;
    end else if (excp_taken && excp_info[EXCP_ILG_INST]) begin
      mtval_wr_data = XLEN'(now_inst);
    end else if (excp_taken && mem_fault) begin
      mtval_wr_data = mem_addr;
    end
  end

  // interrupt enable stack
  always_comb begin
    mstatus_enter                = mstatus;
    mstatus_enter[MSTATUS_MPIE]  = mstatus[MSTATUS_MIE];
    mstatus_enter[MSTATUS_MIE]   = 1'b0;
    mstatus_exit                 = mstatus;
    mstatus_exit[MSTATUS_MIE]    = mstatus[MSTATUS_MPIE];
    mstatus_exit[MSTATUS_MPIE]   = 1'b1;
  end

  assign mstatus_wr_data = trap_enter ? mstatus_enter :
                           excp_exit  ? mstatus_exit  : mstatus;

  // vectored mode offsets interrupts by 4 * code
  assign mtvec_vectored = (mtvec[1:0] == MTVEC_MODE_VECTORED);
  assign mtvec_base     = {mtvec[XLEN-1:2], 2'b00};
  assign enter_pc       = (mtvec_vectored && itrp_allowin) ?
                          mtvec_base + (XLEN'(itrp_code) << 2) : mtvec_base;

  assign trap_jmp_ena = trap_enter | excp_exit;
  assign trap_jmp_pc  = trap_enter ? enter_pc :
                        excp_exit  ? mepc     : '0;

  assign itrp_no = itrp_allowin ? 32'(itrp_code) : '0;
  assign excp_no = excp_taken   ? 32'(excp_code) : '0;

endmodule

`default_nettype wire

// ==== src/trap_unit_top.sv ====
// trap_unit_top: machine CSR file and trap handler joined to the unit ports
`default_nettype none

module trap_unit_top
  import csr_defs_pkg::*;
  import trap_cause_pkg::*;
(
  input  logic                  clk,
  input  logic                  arst_n,

  // pipeline
  input  logic [EXCP_W-1:0]     excp_info,
  input  logic [XLEN-1:0]       now_pc,
  input  logic [31:0]           now_inst,
  input  logic [XLEN-1:0]       mem_addr,
  input  logic                  excp_exit,

  // interrupt lines
  input  logic                  soft_irq,
  input  logic                  timer_irq,
  input  logic                  exter_irq,

  // software CSR port
  input  logic [CSR_ADDR_W-1:0] csr_rd_addr,
  output logic [XLEN-1:0]       csr_rd_data,
  input  logic                  csr_wr_en,
  input  logic [CSR_ADDR_W-1:0] csr_wr_addr,
  input  logic [XLEN-1:0]       csr_wr_data,

  // redirect and difftest
  output logic                  trap_jmp_ena,
  output logic [XLEN-1:0]       trap_jmp_pc,
  output logic                  itrp_valid,
  output logic [31:0]           itrp_no,
  output logic [31:0]           excp_no
);

  logic            trap_enter;
  mcause_u         mcause_wr_data;
  logic [XLEN-1:0] mepc_wr_data;
  logic [XLEN-1:0] mtval_wr_data;
  logic [XLEN-1:0] mstatus_wr_data;
  logic [XLEN-1:0] mstatus;
  logic [XLEN-1:0] mtvec;
  logic [XLEN-1:0] mepc;
  logic [XLEN-1:0] mie;
  logic [XLEN-1:0] mip;

  machine_csr_file u_csr_file (
    .clk             (clk),
    .arst_n          (arst_n),
    .soft_irq        (soft_irq),
    .timer_irq       (timer_irq),
    .exter_irq       (exter_irq),
    .csr_rd_addr     (csr_rd_addr),
    .csr_rd_data     (csr_rd_data),
    .csr_wr_en       (csr_wr_en),
    .csr_wr_addr     (csr_wr_addr),
    .csr_wr_data     (csr_wr_data),
    .trap_enter      (trap_enter),
    .excp_exit       (excp_exit),
    .mcause_wr_data  (mcause_wr_data),
    .mepc_wr_data    (mepc_wr_data),
    .mtval_wr_data   (mtval_wr_data),
    .mstatus_wr_data (mstatus_wr_data),
    .mstatus         (mstatus),
    .mtvec           (mtvec),
    .mepc            (mepc),
    .mie             (mie),
    .mip             (mip)
  );

  trap_handler u_handler (
    .excp_info       (excp_info),
    .now_pc          (now_pc),
    .now_inst        (now_inst),
    .mem_addr        (mem_addr),
    .excp_exit       (excp_exit),
    .mstatus         (mstatus),
    .mtvec           (mtvec),
    .mepc            (mepc),
    .mie             (mie),
    .mip             (mip),
    .trap_enter      (trap_enter),
    .itrp_valid      (itrp_valid),
    .mcause_wr_data  (mcause_wr_data),
    .mepc_wr_data    (mepc_wr_data),
    .mtval_wr_data   (mtval_wr_data),
    .mstatus_wr_data (mstatus_wr_data),
    .trap_jmp_ena    (trap_jmp_ena),
    .trap_jmp_pc     (trap_jmp_pc),
    .itrp_no         (itrp_no),
    .excp_no         (excp_no)
  );

endmodule

`default_nettype wire

// ==== tests/trap_unit_sva.sv ====
// concurrent assertions on the trap unit top, attached by bind
`default_nettype none

module trap_unit_sva
  import trap_cause_pkg::*;
(
  input logic              clk,
  input logic              arst_n,
  input logic [EXCP_W-1:0] excp_info,
  input logic              excp_exit,
  input logic              itrp_valid,
  input logic              trap_jmp_ena
);

  timeunit 1ns;
  timeprecision 1ps;

  // mret and a new trap never share a cycle
  exit_without_cause: assert property (@(posedge clk) disable iff (!arst_n)
    excp_exit |-> (excp_info == '0))
    else $error("excp_exit raised together with an exception strobe");

  // pipeline gives at most one exception per cycle
  excp_onehot: assert property (@(posedge clk) disable iff (!arst_n)
    $onehot0(excp_info))
    else $error("more than one exception strobe high");

  // interrupt entry clears MIE, so no second entry right after
  itrp_redirects: assert property (@(posedge clk) disable iff (!arst_n)
    itrp_valid |-> trap_jmp_ena ##1 !itrp_valid)
    else $error("itrp_valid without redirect or taken twice in a row");

  quiet_in_reset: assert property (@(posedge clk)
    !arst_n |-> !trap_jmp_ena)
    else $error("trap_jmp_ena high during reset");

endmodule

bind trap_unit_top trap_unit_sva u_sva (
  .clk          (clk),
  .arst_n       (arst_n),
  .excp_info    (excp_info),
  .excp_exit    (excp_exit),
  .itrp_valid   (itrp_valid),
  .trap_jmp_ena (trap_jmp_ena)
);

`default_nettype wire

// ==== tests/trap_unit_tb.sv ====
// clock, reset, LFSR stimulus, compare tasks, directed tests and watchdog
`default_nettype none

module trap_unit_tb
  import csr_defs_pkg::*;
  import trap_cause_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int CLK_PERIOD   = 20;
  localparam int RESET_CYCLES = 5;
  // reset, reset check, 12 exceptions, interrupt, masking, return, software
  localparam int TEST_CYCLES  = RESET_CYCLES + 20 + 12 * 10 + 30 + 20 + 24 + 12;
  localparam int WATCHDOG_NS  = (TEST_CYCLES + 100) * CLK_PERIOD;
  localparam logic [31:0]     LFSR_TAPS = 32'h8020_0003;
  localparam logic [XLEN-1:0] DIR_BASE  = 64'h0000_0000_8000_0040;
  localparam logic [XLEN-1:0] VEC_BASE  = 64'h0000_0000_8000_1000;
  localparam logic [XLEN-1:0] MIE_ALL   = 64'h888;

  logic                  clk = 1'b0;
  logic                  arst_n;
  logic [EXCP_W-1:0]     excp_info;
  logic [XLEN-1:0]       now_pc;
  logic [31:0]           now_inst;
  logic [XLEN-1:0]       mem_addr;
  logic                  excp_exit;
  logic                  soft_irq;
  logic                  timer_irq;
  logic                  exter_irq;
  logic [CSR_ADDR_W-1:0] csr_rd_addr;
  logic [XLEN-1:0]       csr_rd_data;
  logic                  csr_wr_en;
  logic [CSR_ADDR_W-1:0] csr_wr_addr;
  logic [XLEN-1:0]       csr_wr_data;
  logic                  trap_jmp_ena;
  logic [XLEN-1:0]       trap_jmp_pc;
  logic                  itrp_valid;
  logic [31:0]           itrp_no;
  logic [31:0]           excp_no;
  logic [31:0]           lfsr_state = 32'h7ce5;

  trap_unit_top uut (
    .clk          (clk),
    .arst_n       (arst_n),
    .excp_info    (excp_info),
    .now_pc       (now_pc),
    .now_inst     (now_inst),
    .mem_addr     (mem_addr),
    .excp_exit    (excp_exit),
    .soft_irq     (soft_irq),
    .timer_irq    (timer_irq),
    .exter_irq    (exter_irq),
    .csr_rd_addr  (csr_rd_addr),
    .csr_rd_data  (csr_rd_data),
    .csr_wr_en    (csr_wr_en),
    .csr_wr_addr  (csr_wr_addr),
    .csr_wr_data  (csr_wr_data),
    .trap_jmp_ena (trap_jmp_ena),
    .trap_jmp_pc  (trap_jmp_pc),
    .itrp_valid   (itrp_valid),
    .itrp_no      (itrp_no),
    .excp_no      (excp_no)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ LFSR_TAPS) : (s >> 1);
  endfunction

  // one LFSR step per bit taken
  function automatic logic [XLEN-1:0] next_bits(input int n);
    logic [XLEN-1:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_step(lfsr_state);
      r = {r[XLEN-2:0], lfsr_state[0]};
    end
    return r;
  endfunction

  // mcause codes by strobe position
  function automatic int expected_code(input int k);
    case (k)
      EXCP_ECALL_M:   return 11;
      EXCP_INST_PAGE: return 12;
      EXCP_LOAD_PAGE: return 13;
      EXCP_STOR_PAGE: return 15;
      default:        return k;
    endcase
  endfunction

  function automatic logic [XLEN-1:0] expected_mtval(input int k, input logic [XLEN-1:0] pc,
                                                     input logic [31:0] inst,
                                                     input logic [XLEN-1:0] addr);
    case (k)
      EXCP_INST_MISAL, EXCP_INST_ACC, EXCP_INST_PAGE: return pc;
      EXCP_ILG_INST: return XLEN'(inst);
      EXCP_LOAD_MISAL, EXCP_LOAD_ACC, EXCP_STOR_MISAL,
      EXCP_STOR_ACC, EXCP_LOAD_PAGE, EXCP_STOR_PAGE: return addr;
      default: return '0;
    endcase
  endfunction

  function automatic mcause_u make_cause(input logic intr, input int code);
    mcause_u c;
    c = '0;
    if (intr) begin
      c.itrp_view.intr      = 1'b1;
      c.itrp_view.itrp_code = (XLEN-1)'(code);
    end else begin
      c.excp_view.excp_code = (XLEN-1)'(code);
    end
    return c;
  endfunction

  task automatic stop_run(input string msg);
    $display("%s", msg);
    $display("*** FAILED ***");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic check_word(input string name, input logic [XLEN-1:0] exp,
                            input logic [XLEN-1:0] act);
    if (act !== exp) begin
      stop_run($sformatf("Error: %s expected %h actual %h", name, exp, act));
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      stop_run($sformatf("Error: %s expected %b actual %b", name, exp, act));
    end
  endtask

  // code field is compared in the view that the flag selects
  task automatic check_cause(input string name, input mcause_u exp, input mcause_u act);
    logic ok;
    if (act.excp_view.intr !== exp.excp_view.intr) begin
      ok = 1'b0;
    end else if (exp.itrp_view.intr) begin
      ok = (act.itrp_view.itrp_code === exp.itrp_view.itrp_code);
    end else begin
      ok = (act.excp_view.excp_code === exp.excp_view.excp_code);
    end
    if (!ok) begin
      stop_run($sformatf("Error: %s expected %h actual %h", name, exp, act));
    end
  endtask

  task automatic csr_write(input logic [CSR_ADDR_W-1:0] addr, input logic [XLEN-1:0] data);
    @(posedge clk);
    csr_wr_en   <= 1'b1;
    csr_wr_addr <= addr;
    csr_wr_data <= data;
    @(posedge clk);
    csr_wr_en   <= 1'b0;
  endtask

  task automatic expect_csr(input string name, input logic [CSR_ADDR_W-1:0] addr,
                            input logic [XLEN-1:0] exp);
    @(posedge clk);
    csr_rd_addr <= addr;
    @(negedge clk);
    check_word(name, exp, csr_rd_data);
  endtask

  task automatic expect_cause(input string name, input mcause_u exp);
    mcause_u act;
    @(posedge clk);
    csr_rd_addr <= CSR_MCAUSE;
    @(negedge clk);
    act = csr_rd_data;
    check_cause(name, exp, act);
  endtask

  task automatic reset_values();
    @(negedge clk);
    check_bit("reset jmp_ena", 1'b0, trap_jmp_ena);
    check_bit("reset itrp_valid", 1'b0, itrp_valid);
    expect_csr("reset mstatus", CSR_MSTATUS, '0);
    expect_csr("reset mie", CSR_MIE, '0);
    expect_csr("reset mtvec", CSR_MTVEC, '0);
    expect_csr("reset mepc", CSR_MEPC, '0);
    expect_csr("reset mcause", CSR_MCAUSE, '0);
    expect_csr("reset mtval", CSR_MTVAL, '0);
    expect_csr("reset mip", CSR_MIP, '0);
  endtask

  // direct mode, irq lines low, MIE set before each trap
  task automatic exception_entry(input int k);
    logic [XLEN-1:0] pc;
    logic [31:0]     inst;
    logic [XLEN-1:0] addr;
    string           name;
    pc   = next_bits(XLEN);
    inst = 32'(next_bits(32));
    addr = next_bits(XLEN);
    name = $sformatf("excp%0d", k);
    csr_write(CSR_MSTATUS, XLEN'(1) << MSTATUS_MIE);
    @(posedge clk);
    excp_info <= EXCP_W'(1) << k;
    now_pc    <= pc;
    now_inst  <= inst;
    mem_addr  <= addr;
    @(negedge clk);
    check_bit({name, " jmp_ena"}, 1'b1, trap_jmp_ena);
    check_bit({name, " itrp_valid"}, 1'b0, itrp_valid);
    check_word({name, " target"}, DIR_BASE, trap_jmp_pc);
    check_word({name, " excp_no"}, XLEN'(expected_code(k)), XLEN'(excp_no));
    @(posedge clk);
    excp_info <= '0;
    expect_csr({name, " mepc"}, CSR_MEPC, pc);
    expect_cause({name, " mcause"}, make_cause(1'b0, expected_code(k)));
    expect_csr({name, " mtval"}, CSR_MTVAL, expected_mtval(k, pc, inst, addr));
    expect_csr({name, " mstatus"}, CSR_MSTATUS, XLEN'(1) << MSTATUS_MPIE);
  endtask

  task automatic vectored_interrupt();
    csr_write(CSR_MTVEC, VEC_BASE | XLEN'(MTVEC_MODE_VECTORED));
    csr_write(CSR_MIE, MIE_ALL);
    csr_write(CSR_MSTATUS, XLEN'(1) << MSTATUS_MIE);
    @(posedge clk);
    timer_irq <= 1'b1;
    @(negedge clk);
    check_bit("timer before mip", 1'b0, itrp_valid);
    @(negedge clk);
    check_bit("timer itrp_valid", 1'b1, itrp_valid);
    check_word("timer target", VEC_BASE + XLEN'(4 * 7), trap_jmp_pc);
    check_word("timer itrp_no", XLEN'(7), XLEN'(itrp_no));
    @(posedge clk);
    timer_irq <= 1'b0;
    expect_cause("timer mcause", make_cause(1'b1, 7));
    csr_write(CSR_MSTATUS, XLEN'(1) << MSTATUS_MIE);
    @(posedge clk);
    timer_irq <= 1'b1;
    exter_irq <= 1'b1;
    @(posedge clk);
    @(negedge clk);
    check_bit("exter itrp_valid", 1'b1, itrp_valid);
    check_word("exter target", VEC_BASE + XLEN'(4 * 11), trap_jmp_pc);
    check_word("exter itrp_no", XLEN'(11), XLEN'(itrp_no));
    @(posedge clk);
    timer_irq <= 1'b0;
    exter_irq <= 1'b0;
    expect_cause("exter mcause", make_cause(1'b1, 11));
  endtask

  // MIE is clear after the last interrupt entry
  task automatic interrupt_masking();
    @(posedge clk);
    soft_irq <= 1'b1;
    @(posedge clk);
    @(negedge clk);
    check_bit("masked by MIE", 1'b0, trap_jmp_ena);
    expect_csr("masked mip", CSR_MIP, XLEN'(1) << ITRP_SOFT);
    csr_write(CSR_MIE, MIE_ALL & ~(XLEN'(1) << ITRP_SOFT));
    csr_write(CSR_MSTATUS, XLEN'(1) << MSTATUS_MIE);
    @(negedge clk);
    check_bit("masked by mie", 1'b0, trap_jmp_ena);
    expect_csr("masked mip again", CSR_MIP, XLEN'(1) << ITRP_SOFT);
    @(posedge clk);
    soft_irq <= 1'b0;
    @(posedge clk);
  endtask

  task automatic trap_return(input string name, input logic [XLEN-1:0] old_mstatus);
    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] exp;
    pc  = next_bits(XLEN);
    exp = old_mstatus;
    exp[MSTATUS_MIE]  = old_mstatus[MSTATUS_MPIE];
    exp[MSTATUS_MPIE] = 1'b1;
    csr_write(CSR_MEPC, pc);
    csr_write(CSR_MSTATUS, old_mstatus);
    @(posedge clk);
    excp_exit <= 1'b1;
    @(negedge clk);
    check_bit({name, " jmp_ena"}, 1'b1, trap_jmp_ena);
    check_bit({name, " itrp_valid"}, 1'b0, itrp_valid);
    check_word({name, " target"}, pc, trap_jmp_pc);
    @(posedge clk);
    excp_exit <= 1'b0;
    expect_csr({name, " mstatus"}, CSR_MSTATUS, exp);
    expect_csr({name, " mepc"}, CSR_MEPC, pc);
  endtask

  task automatic software_access();
    logic [XLEN-1:0] addr;
    logic [XLEN-1:0] sw_data;
    addr    = next_bits(XLEN);
    sw_data = next_bits(XLEN);
    @(posedge clk);
    excp_info   <= EXCP_W'(1) << EXCP_LOAD_ACC;
    mem_addr    <= addr;
    csr_wr_en   <= 1'b1;
    csr_wr_addr <= CSR_MTVAL;
    csr_wr_data <= sw_data;
    @(posedge clk);
    excp_info <= '0;
    csr_wr_en <= 1'b0;
    expect_csr("sw mtval loses", CSR_MTVAL, addr);
    // mip is read in the cycle right after the write edge
    @(posedge clk);
    csr_rd_addr <= CSR_MIP;
    csr_wr_en   <= 1'b1;
    csr_wr_addr <= CSR_MIP;
    csr_wr_data <= '1;
    @(posedge clk);
    csr_wr_en <= 1'b0;
    @(negedge clk);
    check_word("sw mip ignored", '0, csr_rd_data);
  endtask

  initial begin
    arst_n      <= 1'b0;
    excp_info   <= '0;
    now_pc      <= '0;
    now_inst    <= '0;
    mem_addr    <= '0;
    excp_exit   <= 1'b0;
    soft_irq    <= 1'b0;
    timer_irq   <= 1'b0;
    exter_irq   <= 1'b0;
    csr_rd_addr <= '0;
    csr_wr_en   <= 1'b0;
    csr_wr_addr <= '0;
    csr_wr_data <= '0;
    repeat (RESET_CYCLES) @(posedge clk);
    arst_n <= 1'b1;
    reset_values();
    csr_write(CSR_MTVEC, DIR_BASE);
    for (int k = 0; k < EXCP_W; k++) begin
      exception_entry(k);
    end
    vectored_interrupt();
    interrupt_masking();
    trap_return("ret mpie set", XLEN'(1) << MSTATUS_MPIE);
    trap_return("ret mpie clear", XLEN'(1) << MSTATUS_MIE);
    software_access();
    $display("*** PASSED ***");
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    stop_run("watchdog expired before the tests finished");
  end

endmodule

`default_nettype wire
